// ==== Makefile ====
# Verilator build and run of the DSP framing testbench

VERILATOR ?= verilator
TOP       ?= tb_dsp_frame
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) testbench/tb_checks.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_checks.svh ====
// compare tasks and the expected frame model, included into the DSP framing testbench top
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// prints the reason and stops the run
task automatic report_failure(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "stopped at first failure");
endtask

task automatic check_word(input logic [35:0] got, input logic [35:0] exp);
    word_tag_e got_tag;
    word_tag_e exp_tag;
    got_tag = word_tag_e'(got[35:32]);
    exp_tag = word_tag_e'(exp[35:32]);
    if (got !== exp)
        report_failure($sformatf("[ERROR] frame_data got 0x%09h (%s) exp 0x%09h (%s)",
                                 got, got_tag.name(), exp, exp_tag.name()));
endtask

task automatic check_apb(input logic [7:0] addr, input logic [31:0] got_data,
                         input logic got_err, input logic [31:0] exp_data,
                         input logic exp_err, input bit cmp_data);
    if (got_err !== exp_err)
        report_failure($sformatf("[ERROR] pslverr at offset 0x%02h got 0x%0h exp 0x%0h",
                                 addr, got_err, exp_err));
    else if (cmp_data && got_data !== exp_data)
        report_failure($sformatf("[ERROR] prdata at offset 0x%02h got 0x%08h exp 0x%08h",
                                 addr, got_data, exp_data));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
        report_failure($sformatf("[ERROR] %s got 0x%0h exp 0x%0h", name, got, exp));
endtask

// header word with sequence and byte count, followed by the collected samples
task automatic queue_frame(input logic [15:0] seq);
    int        n;
    word_tag_e tag;
    n = pend_q.size();
    exp_q.push_back({HEADER, seq, 16'(4 * n)});
    for (int i = 0; i < n; i++) begin
        tag = (i == n - 1) ? LAST : DATA;
        exp_q.push_back({tag, pend_q[i]});
    end
endtask

`endif

// ==== testbench/tb_dsp_frame.sv ====
// testbench top that runs table-driven frames through the DSP framing subsystem and scores them
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_frame
    import dsp_frame_pkg::*;
();

    localparam int BUF_ADDR_W = 4;
    localparam int SEED       = 82616;
    localparam int NUM_ROWS   = 6;
    // packet length, sample count, output stall percentage
    localparam int ROW_LEN   [NUM_ROWS] = '{1, 3, 15, 3, 15, 1};
    localparam int ROW_CNT   [NUM_ROWS] = '{4, 9, 30, 12, 45, 6};
    localparam int ROW_STALL [NUM_ROWS] = '{0, 0, 0, 40, 50, 50};

    logic        clk = 1'b0;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;
    logic [31:0] sample_data;
    logic        sample_valid;
    wire         sample_ready;
    wire  [35:0] frame_data;
    wire         frame_valid;
    logic        frame_ready;

    logic [35:0] exp_q [$];
    logic [31:0] pend_q [$];
    logic [15:0] exp_seq;
    int          frames_in;
    int          frames_rx;
    int          frames_expect;
    int          cur_len;
    int unsigned stall_pct;
    logic [31:0] next_sample;

    dsp_frame_top #(.BUF_ADDR_W(BUF_ADDR_W)) u_dut (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .sample_data(sample_data), .sample_valid(sample_valid), .sample_ready(sample_ready),
        .frame_data(frame_data), .frame_valid(frame_valid), .frame_ready(frame_ready)
    );

    always #4 clk = ~clk;

    `include "tb_checks.svh"

    function automatic int watchdog_cycles();
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++)
            total = total + ROW_CNT[r] * 4 + 100;
        return total;
    endfunction

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        // the slave never inserts wait states
        check_bit("pready", pready, 1'b1);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_apb(addr, rdata, err, 32'd0, exp_err, 1'b0);
    endtask

    task automatic reg_read(input logic [7:0] addr, input logic [31:0] exp_data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        check_apb(addr, rdata, err, exp_data, exp_err, 1'b1);
    endtask

    task automatic send_samples(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            sample_valid = 1'b1;
            sample_data  = next_sample;
            @(posedge clk);
            while (!sample_ready)
                @(posedge clk);
            next_sample = next_sample + 32'd1;
        end
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0)
            @(posedge clk);
        @(negedge clk);
        if (frames_rx != frames_expect)
            report_failure("number of LAST words received differs from the frames sent");
    endtask

    // offer samples while disabled and expect no movement at all
    task automatic check_blocked(input int cycles);
        @(negedge clk);
        sample_valid = 1'b1;
        sample_data  = 32'hdead_0000;
        repeat (cycles) begin
            @(posedge clk);
            check_bit("sample_ready", sample_ready, 1'b0);
            check_bit("frame_valid", frame_valid, 1'b0);
        end
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    task automatic run_row(input int r);
        reg_write(PKT_LEN, 32'(ROW_LEN[r]), 1'b0);
        cur_len       = ROW_LEN[r];
        stall_pct     = ROW_STALL[r];
        frames_expect = frames_expect + ROW_CNT[r] / ROW_LEN[r];
        send_samples(ROW_CNT[r]);
        wait_drained();
        reg_read(FRAME_CNT, 32'(frames_expect), 1'b0);
    endtask

    always @(posedge clk) begin : scoreboard
        logic [35:0] exp_w;
        logic        last_vis;
        last_vis = frame_valid && (frame_data[35:32] == LAST);
        if (!rst_n) begin
            exp_seq   = 16'd0;
            frames_in = 0;
            frames_rx = 0;
        end else begin
            // input opens only after every complete frame has reached the tagger
            if (sample_ready && (frames_in != frames_rx + (last_vis ? 1 : 0)))
                report_failure("sample_ready went high while a frame was being read out");
            if (frame_valid && frame_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("a word left the frame output with none expected");
                end else begin
                    exp_w = exp_q.pop_front();
                    check_word(frame_data, exp_w);
                    if (frame_data[35:32] == LAST)
                        frames_rx = frames_rx + 1;
                end
            end
            if (sample_valid && sample_ready) begin
                pend_q.push_back(sample_data);
                if (pend_q.size() == cur_len) begin
                    queue_frame(exp_seq);
                    exp_seq   = exp_seq + 16'd1;
                    frames_in = frames_in + 1;
                    pend_q.delete();
                end
            end
            // soft clear drops a partial frame and restarts the sequence
            if (psel && penable && pwrite && paddr == CTRL && pwdata[1] && !pslverr) begin
                exp_q.delete();
                pend_q.delete();
                exp_seq   = 16'd0;
                frames_in = 0;
                frames_rx = 0;
            end
        end
    end

    initial begin : stall_gen
        frame_ready = 1'b0;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            frame_ready = (($urandom % 100) >= stall_pct);
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles()) @(posedge clk);
        $display("timeout: frames stopped arriving");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        rst_n         = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = 8'h00;
        pwdata        = 32'd0;
        sample_data   = 32'd0;
        sample_valid  = 1'b0;
        cur_len       = 1;
        stall_pct     = 0;
        frames_expect = 0;
        next_sample   = 32'h0000_1000;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_blocked(10);

        reg_read(CTRL, 32'd0, 1'b0);
        reg_read(PKT_LEN, 32'd0, 1'b0);
        reg_read(FRAME_CNT, 32'd0, 1'b0);
        reg_write(PKT_LEN, 32'd7, 1'b0);
        reg_read(PKT_LEN, 32'd7, 1'b0);
        // out-of-range lengths leave the old value
        reg_write(PKT_LEN, 32'd0, 1'b1);
        reg_read(PKT_LEN, 32'd7, 1'b0);
        reg_write(PKT_LEN, 32'd16, 1'b1);
        reg_read(PKT_LEN, 32'd7, 1'b0);
        reg_write(FRAME_CNT, 32'd5, 1'b1);
        reg_read(FRAME_CNT, 32'd0, 1'b0);
        reg_write(8'h0C, 32'd1, 1'b1);
        reg_read(8'h0C, 32'd0, 1'b1);
        reg_read(CTRL, 32'd0, 1'b0);
        reg_write(CTRL, 32'd1, 1'b0);
        reg_read(CTRL, 32'd1, 1'b0);

        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);

        reg_write(CTRL, 32'd0, 1'b0);
        check_blocked(10);
        reg_write(CTRL, 32'd1, 1'b0);

        // clear in the middle of a frame, then one clean frame from sequence 0
        reg_write(PKT_LEN, 32'd5, 1'b0);
        cur_len   = 5;
        stall_pct = 30;
        send_samples(3);
        reg_write(CTRL, 32'd3, 1'b0);
        frames_expect = 0;
        reg_read(FRAME_CNT, 32'd0, 1'b0);
        frames_expect = 1;
        send_samples(5);
        wait_drained();
        reg_read(FRAME_CNT, 32'd1, 1'b0);

        if (exp_q.size() == 0 && pend_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            report_failure("expected words were left over at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dsp_frame_pkg.sv ====
// shared stream-word tags, framer states and APB register offsets for the DSP framing path
`default_nettype none

package dsp_frame_pkg;

    // tag nibble in bits 35:32 of every 36-bit stream word
    typedef enum logic [3:0] {
        DATA   = 4'd0,
        HEADER = 4'd1,
        LAST   = 4'd2
    } word_tag_e;

    // on the packer output the tag nibble carries frame flags instead
    localparam int SOF_BIT = 32;
    localparam int EOF_BIT = 33;

    typedef enum logic [1:0] {
        WAIT_SOF  = 2'd0,
        WAIT_EOF  = 2'd1,
        WRITE_HDR = 2'd2,
        WRITE     = 2'd3
    } framer_state_e;

    // APB byte offsets
    typedef enum logic [7:0] {
        CTRL      = 8'h00,
        PKT_LEN   = 8'h04,
        FRAME_CNT = 8'h08
    } apb_reg_e;

endpackage

`default_nettype wire

// ==== verilog/dsp_frame_top.sv ====
// top level of the DSP framing subsystem, wires the APB registers, packer, framer and tagger
`timescale 1ns/1ps
`default_nettype none

module dsp_frame_top #(
    parameter int BUF_ADDR_W = 9
) (
    input  wire         clk,
    input  wire         rst_n,
    // APB configuration port
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [7:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // sample input
    input  wire  [31:0] sample_data,
    input  wire         sample_valid,
    output logic        sample_ready,
    // framed output
    output logic [35:0] frame_data,
    output logic        frame_valid,
    input  wire         frame_ready
);

    wire                  enable;
    wire                  clr;
    wire [BUF_ADDR_W-1:0] pkt_len;
    wire [15:0]           frame_cnt;
    wire [35:0]           pack_data;
    wire                  pack_valid;
    wire                  pack_ready;
    wire [35:0]           frm_data;
    wire                  frm_valid;
    wire                  frm_ready;

    frame_apb_regs #(.BUF_ADDR_W(BUF_ADDR_W)) u_regs (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .frame_cnt(frame_cnt),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .enable(enable), .clr(clr), .pkt_len(pkt_len)
    );

    sample_packer #(.BUF_ADDR_W(BUF_ADDR_W)) u_packer (
        .clk(clk), .rst_n(rst_n), .clr(clr), .enable(enable), .pkt_len(pkt_len),
        .sample_data(sample_data), .sample_valid(sample_valid), .sample_ready(sample_ready),
        .pack_data(pack_data), .pack_valid(pack_valid), .pack_ready(pack_ready)
    );

    dsp_framer #(.BUF_ADDR_W(BUF_ADDR_W)) u_framer (
        .clk(clk), .rst_n(rst_n), .clr(clr),
        .inp_data(pack_data), .inp_valid(pack_valid), .inp_ready(pack_ready),
        .out_data(frm_data), .out_valid(frm_valid), .out_ready(frm_ready)
    );

    frame_tagger u_tagger (
        .clk(clk), .rst_n(rst_n), .clr(clr),
        .tag_in_data(frm_data), .tag_in_valid(frm_valid), .tag_in_ready(frm_ready),
        .tag_out_data(frame_data), .tag_out_valid(frame_valid), .tag_out_ready(frame_ready),
        .frame_cnt(frame_cnt)
    );

endmodule

`default_nettype wire

// ==== verilog/dsp_framer.sv ====
// store-and-forward framer, buffers a whole frame then sends a byte-count header and the words
`timescale 1ns/1ps
`default_nettype none

module dsp_framer
    import dsp_frame_pkg::*;
#(
    parameter int BUF_ADDR_W = 9
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         clr,
    input  wire  [35:0] inp_data,
    input  wire         inp_valid,
    input  wire         out_ready,
    output logic        inp_ready,
    output logic [35:0] out_data,
    output logic        out_valid
);

    framer_state_e         state;
    framer_state_e         state_d;
    logic [BUF_ADDR_W-1:0] addr;
    logic [BUF_ADDR_W-1:0] addr_next;
    logic [BUF_ADDR_W-1:0] count;
    logic [31:0]           mem [2**BUF_ADDR_W];
    logic [31:0]           rd_q;
    logic                  in_fire;
    logic                  out_fire;
    logic                  frame_word;
    logic                  frame_end;
    logic                  rd_en;
    logic                  last;
    logic [15:0]           byte_cnt;

    assign addr_next = addr + 1'b1;
    assign in_fire   = inp_valid & inp_ready;
    assign out_fire  = out_valid & out_ready;

    // words before a start flag are dropped while idle
    assign frame_word = in_fire & ((state == WAIT_EOF) | inp_data[SOF_BIT]);
    assign frame_end  = frame_word & inp_data[EOF_BIT];

    // addr runs one ahead of the word in rd_q during readout
    assign last     = (addr == count);
    assign byte_cnt = 16'({count, 2'b00});

    // prefetch word 0 while the header waits, then one read per accepted word
    assign rd_en = (state == WRITE_HDR) | ((state == WRITE) & out_fire);

    assign out_valid = (state == WRITE_HDR) | (state == WRITE);

    always_comb begin
        if (state == WRITE_HDR)
            out_data = {HEADER, 16'h0000, byte_cnt};
        else if (last)
            out_data = {LAST, rd_q};
        else
            out_data = {DATA, rd_q};
    end

    always_comb begin
        state_d = state;
        case (state)
            WAIT_SOF,
            WAIT_EOF: begin
                if (frame_end)
                    state_d = WRITE_HDR;
                else if (frame_word)
                    state_d = WAIT_EOF;
            end
            WRITE_HDR: if (out_fire) state_d = WRITE;
            WRITE:     if (out_fire && last) state_d = WAIT_SOF;
            default:   state_d = WAIT_SOF;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= WAIT_SOF;
            addr      <= '0;
            inp_ready <= 1'b0;
        end else if (clr) begin
            state     <= WAIT_SOF;
            addr      <= '0;
            inp_ready <= 1'b1;
        end else begin
            state     <= state_d;
            inp_ready <= (state_d == WAIT_SOF) | (state_d == WAIT_EOF);
            if (frame_word)
                addr <= frame_end ? '0 : addr_next;
            else if (out_fire)
                addr <= (state == WRITE && last) ? '0 : addr_next;
        end
    end

    // word count of the frame just stored
    always_ff @(posedge clk) begin
        if (frame_end)
            count <= addr_next;
    end

    // dual-port buffer, write side fills and read side drains, never in the same state
    always_ff @(posedge clk) begin
        if (frame_word)
            mem[addr] <= inp_data[31:0];
        if (rd_en)
            rd_q <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== verilog/frame_apb_regs.sv ====
// APB slave with enable, soft clear and packet length control plus frame count readback
`timescale 1ns/1ps
`default_nettype none

module frame_apb_regs
    import dsp_frame_pkg::*;
#(
    parameter int BUF_ADDR_W = 9
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  wire [7:0]             paddr,
    input  wire [31:0]            pwdata,
    input  wire [15:0]            frame_cnt,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  enable,
    output logic                  clr,
    output logic [BUF_ADDR_W-1:0] pkt_len
);

    // longest frame the buffer can hold
    localparam logic [31:0] MAX_LEN = (32'd1 << BUF_ADDR_W) - 32'd1;

    apb_reg_e reg_sel;
    logic     access;
    logic     wr_access;
    logic     addr_ok;
    logic     len_ok;

    assign reg_sel   = apb_reg_e'(paddr);
    assign access    = psel & penable;
    assign wr_access = access & pwrite;
    assign len_ok    = (pwdata != 32'd0) && (pwdata <= MAX_LEN);
    assign pready    = 1'b1;

    always_comb begin
        addr_ok = 1'b1;
        case (reg_sel)
            CTRL:      prdata = {31'd0, enable};
            PKT_LEN:   prdata = {{(32-BUF_ADDR_W){1'b0}}, pkt_len};
            FRAME_CNT: prdata = {16'd0, frame_cnt};
            default: begin
                prdata  = 32'd0;
                addr_ok = 1'b0;
            end
        endcase
    end

    // frame count is read only, bad lengths are refused
    assign pslverr = access & (~addr_ok
                               | (pwrite & (reg_sel == FRAME_CNT))
                               | (pwrite & (reg_sel == PKT_LEN) & ~len_ok));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable  <= 1'b0;
            clr     <= 1'b0;
            pkt_len <= '0;
        end else begin
            // clr is a single-cycle pulse
            clr <= 1'b0;
            if (wr_access && !pslverr) begin
                case (reg_sel)
                    CTRL: begin
                        enable <= pwdata[0];
                        clr    <= pwdata[1];
                    end
                    PKT_LEN: pkt_len <= pwdata[BUF_ADDR_W-1:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/frame_tagger.sv ====
// output stage that stamps the sequence number into each header and counts delivered frames
`timescale 1ns/1ps
`default_nettype none

module frame_tagger
    import dsp_frame_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         clr,
    input  wire  [35:0] tag_in_data,
    input  wire         tag_in_valid,
    input  wire         tag_out_ready,
    output logic        tag_in_ready,
    output logic [35:0] tag_out_data,
    output logic        tag_out_valid,
    output logic [15:0] frame_cnt
);

    logic [15:0] seq;
    logic        in_fire;
    logic        out_fire;
    logic        is_hdr;

    assign in_fire  = tag_in_valid & tag_in_ready;
    assign out_fire = tag_out_valid & tag_out_ready;
    assign is_hdr   = (tag_in_data[35:32] == HEADER);

    // one-deep stage, can refill in the cycle it drains
    assign tag_in_ready = ~tag_out_valid | tag_out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_out_valid <= 1'b0;
            seq           <= '0;
            frame_cnt     <= '0;
        end else if (clr) begin
            tag_out_valid <= 1'b0;
            seq           <= '0;
            frame_cnt     <= '0;
        end else begin
            if (in_fire)
                tag_out_valid <= 1'b1;
            else if (out_fire)
                tag_out_valid <= 1'b0;
            if (in_fire && is_hdr)
                seq <= seq + 16'd1;
            // a frame counts once its last word has left
            if (out_fire && tag_out_data[35:32] == LAST)
                frame_cnt <= frame_cnt + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire)
            tag_out_data <= is_hdr ? {tag_in_data[35:32], seq, tag_in_data[15:0]} : tag_in_data;
    end

endmodule

`default_nettype wire

// ==== verilog/sample_packer.sv ====
// marks start and end of frame on the 32-bit sample stream using the programmed packet length
`timescale 1ns/1ps
`default_nettype none

module sample_packer
    import dsp_frame_pkg::*;
#(
    parameter int BUF_ADDR_W = 9
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  clr,
    input  wire                  enable,
    input  wire [BUF_ADDR_W-1:0] pkt_len,
    input  wire [31:0]           sample_data,
    input  wire                  sample_valid,
    input  wire                  pack_ready,
    output logic                 sample_ready,
    output logic [35:0]          pack_data,
    output logic                 pack_valid
);

    logic [BUF_ADDR_W-1:0] word_cnt;
    logic [BUF_ADDR_W-1:0] cnt_next;
    logic [BUF_ADDR_W-1:0] len_q;
    logic [BUF_ADDR_W-1:0] len_eff;
    logic                  sof;
    logic                  eof;

    assign sample_ready = enable & pack_ready;
    assign pack_valid   = enable & sample_valid;

    // length is sampled on the first word, so changes land on a packet boundary
    assign sof      = (word_cnt == '0);
    assign len_eff  = sof ? pkt_len : len_q;
    assign cnt_next = word_cnt + 1'b1;
    // all-ones cap keeps an unprogrammed length from overrunning the buffer
    assign eof      = (cnt_next == len_eff) | (&cnt_next);

    always_comb begin
        pack_data          = {4'd0, sample_data};
        pack_data[SOF_BIT] = sof;
        pack_data[EOF_BIT] = eof;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
            len_q    <= '0;
        end else if (clr) begin
            word_cnt <= '0;
        end else if (pack_valid && sample_ready) begin
            word_cnt <= eof ? '0 : cnt_next;
            if (sof)
                len_q <= pkt_len;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+testbench
verilog/dsp_frame_pkg.sv
verilog/frame_apb_regs.sv
verilog/sample_packer.sv
verilog/dsp_framer.sv
verilog/frame_tagger.sv
verilog/dsp_frame_top.sv
testbench/tb_dsp_frame.sv
